// File: design/xclk_defs.svh
/* pulse bridge build constants */

`ifndef XCLK_DEFS_SVH
`define XCLK_DEFS_SVH

// channel count, one request lane each
`define XCLK_N_CHAN 2

// request count and pending counter width
`define XCLK_CNT_W 4

// destination tally width, wraps
`define XCLK_TALLY_W 8

// extra dst sync stage for channels above 0
// 0 gives the higher duty cycle, 1 trades rate for margin
`define XCLK_EXTRA_DLY 1

`endif

// File: design/pulse_req_pkg.sv
/* burst request types */

`include "xclk_defs.svh"

package pulse_req_pkg;

    // one channel's burst request, src_clk domain
    typedef struct packed {
        logic                   we;         // one-cycle write strobe
        logic [`XCLK_CNT_W-1:0] num_pulses; // pulses added to pending
    } pulse_req_t;

    // all lanes, index = channel
    typedef pulse_req_t [`XCLK_N_CHAN-1:0] pulse_req_vec_t;

endpackage

// File: design/xclk_status_pkg.sv
/* channel status and tally types */

`include "xclk_defs.svh"

package xclk_status_pkg;

    // per-channel status, mixed domains
    typedef struct packed {
        logic busy;      // src_clk level, pending or in flight
        logic out_pulse; // dst_clk single-cycle pulse
    } chan_status_t;

    // arrived-pulse counts, dst_clk domain
    typedef logic [`XCLK_N_CHAN-1:0][`XCLK_TALLY_W-1:0] tally_vec_t;

endpackage

// File: design/pulse_cross_clock.sv
/* single-pulse clock crossing */

`timescale 1ns/1ns

module pulse_cross_clock #(
    parameter int EXTRA_DLY = 0 // 0 or 1, adds a dst sync stage
) (
    input  logic rst,       // src_clk domain, sync
    input  logic src_clk,
    input  logic dst_clk,
    input  logic in_pulse,  // ignored while busy
    output logic out_pulse, // one dst_clk cycle
    output logic busy       // covers the full round trip
);
    localparam int SYNC_LEN = 2 + EXTRA_DLY;

    logic                src_flag;     // toggles once per launched pulse
    logic [1:0]          ack_sync;     // dst flag back in src_clk
    logic [1:0]          dst_rst_sync; // rst into dst_clk
    logic                dst_rst;
    logic [SYNC_LEN-1:0] dst_sync;     // src_flag into dst_clk

    // round trip open while flag and returned copy differ
    assign busy = src_flag ^ ack_sync[1];

    always_ff @(posedge src_clk) begin
        if (rst) begin
            src_flag <= 1'b0;
        end else if (in_pulse && !busy) begin
            src_flag <= ~src_flag; // launch
        end
    end

    // acknowledge path, last dst stage back to src
    always_ff @(posedge src_clk) begin
        if (rst) begin
            ack_sync <= 2'b00;
        end else begin
            ack_sync <= {ack_sync[0], dst_sync[SYNC_LEN-1]};
        end
    end

    // local dst reset, two flops
    always_ff @(posedge dst_clk) begin
        dst_rst_sync <= {dst_rst_sync[0], rst};
    end

    assign dst_rst = dst_rst_sync[1];

    always_ff @(posedge dst_clk) begin
        if (dst_rst) begin
            dst_sync <= '0;
        end else begin
            dst_sync <= {dst_sync[SYNC_LEN-2:0], src_flag}; // shift toward msb
        end
    end

    // Edge between the last two stages. The last stage updates on the same
    // dst edge that consumes out_pulse, so the ack can never overtake it.
    assign out_pulse = dst_sync[SYNC_LEN-1] ^ dst_sync[SYNC_LEN-2];

endmodule

// File: design/multipulse_cross_clock.sv
/* pulse train clock crossing */

`timescale 1ns/1ns

`include "xclk_defs.svh"

module multipulse_cross_clock
    import pulse_req_pkg::*, xclk_status_pkg::*;
#(
    parameter int WIDTH     = `XCLK_CNT_W, // pending counter width
    parameter int EXTRA_DLY = 0            // passed to the single crossing
) (
    input  logic         rst,
    input  logic         src_clk,
    input  logic         dst_clk,
    input  pulse_req_t   req,   // src_clk domain
    output chan_status_t status
);
    logic [WIDTH-1:0] pend_cntr;   // pulses not yet launched
    logic [WIDTH-1:0] add_cnt;     // this cycle's request
    logic             busy_single; // crossing round trip open
    logic             launch;      // one pulse into crossing
    logic             launch_r;    // decrement, one cycle late
    logic             out_pulse;

    assign add_cnt = req.we ? WIDTH'(req.num_pulses) : '0;

    // next pulse as soon as the crossing frees up
    assign launch = !busy_single && (|pend_cntr);

    always_ff @(posedge src_clk) begin
        if (rst) begin
            launch_r  <= 1'b0;
            pend_cntr <= '0;
        end else begin
            launch_r  <= launch;
            // add and subtract in one step, writes during a burst accumulate
            pend_cntr <= pend_cntr + add_cnt - WIDTH'(launch_r);
        end
    end

    // pending count still nonzero during the late decrement, so the busy
    // crossing already blocks a second launch of the same pulse
    assign status.busy      = busy_single || (|pend_cntr);
    assign status.out_pulse = out_pulse;

    pulse_cross_clock #(
        .EXTRA_DLY (EXTRA_DLY)
    ) i_cross (
        .rst       (rst),
        .src_clk   (src_clk),
        .dst_clk   (dst_clk),
        .in_pulse  (launch),
        .out_pulse (out_pulse),
        .busy      (busy_single)
    );

endmodule

// File: design/pulse_tally.sv
/* destination pulse tally */

`timescale 1ns/1ns

`include "xclk_defs.svh"

module pulse_tally
    import xclk_status_pkg::*;
#(
    parameter int N_CHAN  = `XCLK_N_CHAN,  // channels counted
    parameter int TALLY_W = `XCLK_TALLY_W  // per-channel count width
) (
    input  logic              rst,     // src_clk domain, resynced here
    input  logic              dst_clk,
    input  logic [N_CHAN-1:0] pulses,  // out_pulse per channel
    output tally_vec_t        tally    // dst_clk domain
);
    logic [1:0]                    rst_sync; // rst into dst_clk
    logic                          dst_rst;
    logic [N_CHAN-1:0][TALLY_W-1:0] cnt;     // arrived pulses

    always_ff @(posedge dst_clk) begin
        rst_sync <= {rst_sync[0], rst};
    end

    // same depth as the crossings, so counts clear with their flags
    assign dst_rst = rst_sync[1];

    always_ff @(posedge dst_clk) begin
        if (dst_rst) begin
            cnt <= '0;
        end else begin
            for (int i = 0; i < N_CHAN; i++) begin
                if (pulses[i]) begin
                    cnt[i] <= cnt[i] + TALLY_W'(1); // wraps silently
                end
            end
        end
    end

    assign tally = cnt;

endmodule

// File: design/pulse_bridge_top.sv
/* multi-channel pulse bridge */

`timescale 1ns/1ns

`include "xclk_defs.svh"

module pulse_bridge_top
    import pulse_req_pkg::*, xclk_status_pkg::*;
(
    input  logic                            rst,     // sync, src_clk domain
    input  logic                            src_clk,
    input  logic                            dst_clk,
    input  pulse_req_vec_t                  req,     // one lane per channel
    output chan_status_t [`XCLK_N_CHAN-1:0] status,  // busy and out_pulse
    output tally_vec_t                      tally    // dst_clk counts
);
    logic [`XCLK_N_CHAN-1:0] out_pulses; // gathered for the tally

    for (genvar i = 0; i < `XCLK_N_CHAN; i++) begin : g_chan
        // channel 0 keeps the short sync chain
        multipulse_cross_clock #(
            .WIDTH     (`XCLK_CNT_W),
            .EXTRA_DLY ((i == 0) ? 0 : `XCLK_EXTRA_DLY)
        ) i_chan (
            .rst     (rst),
            .src_clk (src_clk),
            .dst_clk (dst_clk),
            .req     (req[i]),
            .status  (status[i])
        );

        assign out_pulses[i] = status[i].out_pulse;
    end

    pulse_tally #(
        .N_CHAN  (`XCLK_N_CHAN),
        .TALLY_W (`XCLK_TALLY_W)
    ) i_tally (
        .rst     (rst),
        .dst_clk (dst_clk),
        .pulses  (out_pulses),
        .tally   (tally)
    );

endmodule

// File: dv/pulse_bridge_assert.sv
/* pulse bridge assertions */

`timescale 1ns/1ns

`include "xclk_defs.svh"

module pulse_bridge_assert
    import pulse_req_pkg::*, xclk_status_pkg::*;
(
    input logic                            rst,
    input logic                            src_clk,
    input logic                            dst_clk,
    input pulse_req_vec_t                  req,
    input chan_status_t [`XCLK_N_CHAN-1:0] status,
    input tally_vec_t                      tally
);
    localparam int N_CHAN    = `XCLK_N_CHAN;
    localparam int TALLY_W   = `XCLK_TALLY_W;
    localparam int CNT_RANGE = 1 << `XCLK_CNT_W; // pending counter range

    int unsigned chan_fails [N_CHAN]; // per channel, both domains
    int unsigned fail_total;          // read by the testbench

    for (genvar i = 0; i < N_CHAN; i++) begin : g_chk
        logic [TALLY_W-1:0] exp_sum;   // all requested pulses, wraps like tally
        logic [TALLY_W-1:0] in_flight; // requested, not yet tallied
        int unsigned        src_fails;
        int unsigned        dst_fails;

        initial begin
            src_fails = 0;
            dst_fails = 0;
        end

        always_ff @(posedge src_clk) begin
            if (rst) begin
                exp_sum <= '0;
            end else if (req[i].we) begin
                exp_sum <= exp_sum + TALLY_W'(req[i].num_pulses);
            end
        end

        assign in_flight     = exp_sum - tally[i];
        assign chan_fails[i] = src_fails + dst_fails;

        // channel idle right after reset
        a_idle_after_rst: assert property (@(posedge src_clk)
            $fell(rst) |-> !status[i].busy)
            else begin
                $error("error: %0t status[%0d].busy = %0b, expected 0",
                       $time, i, status[i].busy);
                src_fails++;
            end

        a_busy_after_we: assert property (@(posedge src_clk) disable iff (rst)
            req[i].we && (req[i].num_pulses != 0) |=> status[i].busy)
            else begin
                $error("error: %0t status[%0d].busy = %0b, expected 1",
                       $time, i, status[i].busy);
                src_fails++;
            end

        // every requested pulse landed once busy drops
        a_tally_at_idle: assert property (@(posedge src_clk) disable iff (rst)
            $fell(status[i].busy) |-> tally[i] == exp_sum)
            else begin
                $error("error: %0t tally[%0d] = %0d, expected %0d",
                       $time, i, tally[i], exp_sum);
                src_fails++;
            end

        a_pend_range: assert property (@(posedge src_clk) disable iff (rst)
            req[i].we |-> int'(in_flight) + int'(req[i].num_pulses) < CNT_RANGE)
            else begin
                $error("request on channel %0d pushes the pending total past the counter range",
                       i);
                src_fails++;
            end

        // dst side cleared after three dst edges of rst
        a_dst_after_rst: assert property (@(posedge dst_clk)
            rst && $past(rst) && $past(rst, 2) |=> !status[i].out_pulse && tally[i] == '0)
            else begin
                $error("error: %0t tally[%0d] = %0d out_pulse = %0b, expected 0 and 0",
                       $time, i, tally[i], status[i].out_pulse);
                dst_fails++;
            end

        a_single_pulse: assert property (@(posedge dst_clk) disable iff (rst)
            status[i].out_pulse |=> !status[i].out_pulse)
            else begin
                $error("out_pulse on channel %0d stayed high for two dst_clk cycles", i);
                dst_fails++;
            end
    end

    always_comb begin
        fail_total = 0;
        for (int c = 0; c < N_CHAN; c++) begin
            fail_total += chan_fails[c];
        end
    end

endmodule

bind pulse_bridge_top pulse_bridge_assert i_assert (.*);

// File: dv/pulse_bridge_tb.sv
/* pulse bridge testbench */

`timescale 1ns/1ns

`include "xclk_defs.svh"

module pulse_bridge_tb
    import pulse_req_pkg::*, xclk_status_pkg::*;
();
    localparam int N_CHAN      = `XCLK_N_CHAN;
    localparam int CH_W        = (N_CHAN > 1) ? $clog2(N_CHAN) : 1;
    localparam int MAX_BURST   = (1 << `XCLK_CNT_W) - 1; // largest legal pending total
    localparam int TIMEOUT_CYC = 4000;                   // src_clk cycles

    logic                      rst;
    logic                      src_clk;
    logic                      dst_clk;
    pulse_req_vec_t            req;
    chan_status_t [N_CHAN-1:0] status;
    tally_vec_t                tally;
    logic [N_CHAN-1:0]         busy_vec; // busy bits gathered
    int                        cycle_cnt;
    int                        tb_errs;

    initial begin
        src_clk = 1'b0;
        forever #2 src_clk = ~src_clk; // 4 ns
    end

    initial begin
        dst_clk = 1'b0;
        forever #3 dst_clk = ~dst_clk; // 6 ns, edges never meet src edges
    end

    pulse_bridge_top i_dut (
        .rst     (rst),
        .src_clk (src_clk),
        .dst_clk (dst_clk),
        .req     (req),
        .status  (status),
        .tally   (tally)
    );

    for (genvar g = 0; g < N_CHAN; g++) begin : g_busy
        assign busy_vec[g] = status[g].busy;
    end

    always @(posedge src_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // inputs change 1 ns after the src edge
    task automatic next_cycle();
        @(posedge src_clk);
        #1;
    endtask

    task automatic set_lane(input logic [CH_W-1:0] chan, input int n);
        req[chan].we         = 1'b1;
        req[chan].num_pulses = n[`XCLK_CNT_W-1:0];
    endtask

    // one-cycle we on every lane that was set
    task automatic strobe_lanes();
        next_cycle();
        req = '0;
    endtask

    task automatic wait_idle();
        while (|busy_vec) begin
            next_cycle(); // bounded by the timeout
        end
        next_cycle(); // let the fall of busy be sampled
        next_cycle();
    endtask

    function automatic int rand_burst(input int max_n);
        return 1 + int'($urandom % max_n); // 1 .. max_n
    endfunction

    task automatic end_run();
        int a_errs;
        a_errs = int'(i_dut.i_assert.fail_total);
        $display("end of run: testbench errors %0d, assertion errors %0d, %0d cycles",
                 tb_errs, a_errs, cycle_cnt);
        if (tb_errs == 0 && a_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    initial begin
        int n1;
        int n2;
        rst       = 1'b1;
        req       = '0;
        cycle_cnt = 0;
        tb_errs   = 0;
        void'($urandom(32'hc6a3));
        repeat (5) @(posedge src_clk);
        #1;
        rst = 1'b0;
        repeat (4) next_cycle(); // dst reset sync drains
        // one pulse per channel
        for (int c = 0; c < N_CHAN; c++) begin
            set_lane(CH_W'(c), 1);
            strobe_lanes();
            wait_idle();
        end
        // single-lane bursts, lanes in turn
        for (int k = 0; k < 12; k++) begin
            set_lane(CH_W'(k), rand_burst(MAX_BURST));
            strobe_lanes();
            wait_idle();
        end
        // second write lands mid-burst, total kept in range
        for (int k = 0; k < 4; k++) begin
            n1 = rand_burst(MAX_BURST - 1);
            n2 = rand_burst(MAX_BURST - n1);
            set_lane(CH_W'(k), n1);
            strobe_lanes();
            repeat (3) next_cycle();
            set_lane(CH_W'(k), n2);
            strobe_lanes();
            wait_idle();
        end
        // all lanes at once
        for (int k = 0; k < 8; k++) begin
            for (int c = 0; c < N_CHAN; c++) begin
                set_lane(CH_W'(c), rand_burst(MAX_BURST));
            end
            strobe_lanes();
            wait_idle();
        end
        end_run();
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYC);
        $display("timeout: stimulus still running after %0d src_clk cycles", cycle_cnt);
        tb_errs++;
        end_run();
    end

endmodule

// File: build.f
+incdir+design
design/pulse_req_pkg.sv
design/xclk_status_pkg.sv
design/pulse_cross_clock.sv
design/multipulse_cross_clock.sv
design/pulse_tally.sv
design/pulse_bridge_top.sv
dv/pulse_bridge_assert.sv
dv/pulse_bridge_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the pulse bridge simulation with Verilator.

set -u

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
SIM_BIN=sim_pulse_bridge
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
    -f build.f \
    --top-module pulse_bridge_tb \
    -Mdir "${OBJ_DIR}" \
    -o "${SIM_BIN}"
if [ $? -ne 0 ]; then
    echo "run_sim: verilator compile failed"
    exit 1
fi

# keep running past assertion errors so the closing line is printed
"./${OBJ_DIR}/${SIM_BIN}" +verilator+error+limit+1000 > "${LOG_FILE}" 2>&1
sim_status=$?
cat "${LOG_FILE}"
if [ ${sim_status} -ne 0 ]; then
    echo "run_sim: simulation exited with status ${sim_status}"
    exit 1
fi

if grep -q "TEST FAILED" "${LOG_FILE}"; then
    echo "run_sim: failure reported, see ${LOG_FILE}"
    exit 1
fi

echo "run_sim: no failure found in ${LOG_FILE}"
exit 0
